/* design/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // ========================================
    // Geometry
    // ========================================
    // 1 KB direct mapped, 16-byte lines
    localparam int LINE_WORDS = 4;
    localparam int INDEX_W    = 6;
    localparam int TAG_W      = 22;
    localparam int SETS       = 1 << INDEX_W;

    // CPU byte address split
    // Byte offset field cannot be called byte since that is a keyword
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [1:0]         word;
        logic [1:0]         byte_ofs;
    } addr_t;

    // One line, seen flat for storage or as words for beats
    typedef union packed {
        logic [LINE_WORDS*32-1:0]        bits;
        logic [LINE_WORDS-1:0][31:0]     words;
    } line_u;

    // Current occupant of the addressed set
    // dirty already qualified with valid
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             dirty;
        line_u            line;
    } victim_t;

    // Whole-line write into the store
    typedef struct packed {
        logic [INDEX_W-1:0] index;
        logic [TAG_W-1:0]   tag;
        line_u              line;
        logic               dirty;
    } fill_t;

    // Byte-enable merge of a store into a word
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b])
                result[8*b +: 8] = new_word[8*b +: 8];
        end
        return result;
    endfunction

endpackage

`default_nettype wire

/* design/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    // ========================================
    // CPU side
    // ========================================
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [3:0]            be;
        cache_pkg::addr_t      addr;
        logic [31:0]           wdata;
    } cpu_req_t;

    // ready is combinational, rdata zero on stores
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } cpu_rsp_t;

    // ========================================
    // Wishbone side
    // ========================================
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Memory job handed to the line master
    typedef enum logic [1:0] {
        LINE_READ,
        LINE_WRITE,
        SINGLE
    } line_op_e;

    typedef struct packed {
        line_op_e          op;
        logic [31:0]       base;
        cache_pkg::line_u  line;
        logic [31:0]       sdata;
        logic              swe;
        logic [3:0]        sel;
    } line_cmd_t;

endpackage

`default_nettype wire

/* design/l1_store.sv */
`default_nettype none

module l1_store (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire cache_pkg::addr_t lookup_addr_i,
    output logic                  hit_o,
    output logic [31:0]           hit_word_o,
    output cache_pkg::victim_t    victim_o,
    input  wire logic             wr_hit_i,
    input  wire logic [31:0]      wdata_i,
    input  wire logic [3:0]       be_i,
    input  wire cache_pkg::fill_t fill_i,
    input  wire logic             fill_valid_i
);

    // ========================================
    // Arrays
    // ========================================
    logic [cache_pkg::LINE_WORDS*32-1:0] data_mem [cache_pkg::SETS];
    logic [cache_pkg::TAG_W-1:0]         tag_mem  [cache_pkg::SETS];
    logic [cache_pkg::SETS-1:0]          valid_q;
    logic [cache_pkg::SETS-1:0]          dirty_q;

    logic [cache_pkg::INDEX_W-1:0] idx;
    logic [1:0]                    word;
    cache_pkg::line_u              cur_line;
    cache_pkg::line_u              upd_line;

    assign idx  = lookup_addr_i.index;
    assign word = lookup_addr_i.word;

    // Stored flat, read back through the word view
    assign cur_line.bits = data_mem[idx];

    // ========================================
    // Lookup
    // ========================================
    // Combinational, so hits answer in the same cycle
    assign hit_o      = valid_q[idx] && (tag_mem[idx] == lookup_addr_i.tag);
    assign hit_word_o = cur_line.words[word];

    // Occupant of the set, in case this turns into a miss
    assign victim_o.tag   = tag_mem[idx];
    assign victim_o.dirty = valid_q[idx] && dirty_q[idx];
    assign victim_o.line  = cur_line;

    // Only the enabled bytes of the addressed word change on a write hit
    always_comb begin
        upd_line             = cur_line;
        upd_line.words[word] = cache_pkg::merge_bytes(cur_line.words[word], wdata_i, be_i);
    end

    // ========================================
    // Writes
    // ========================================
    // Fill and write hit never coincide, fill wins anyway
    always_ff @(posedge clk) begin
        if (fill_valid_i) begin
            data_mem[fill_i.index] <= fill_i.line.bits;
            tag_mem[fill_i.index]  <= fill_i.tag;
        end else if (wr_hit_i) begin
            data_mem[idx] <= upd_line.bits;
        end
    end

    // Line state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_valid_i) begin
            valid_q[fill_i.index] <= 1'b1;
            dirty_q[fill_i.index] <= fill_i.dirty;
        end else if (wr_hit_i) begin
            dirty_q[idx] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/wb_line_master.sv */
`default_nettype none

module wb_line_master (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               start_i,
    input  wire bus_pkg::line_cmd_t cmd_i,
    output logic                    done_o,
    output cache_pkg::line_u        line_o,
    output logic [31:0]             word_o,
    output bus_pkg::wb_req_t        wb_o,
    input  wire bus_pkg::wb_rsp_t   wb_i
);

    logic               busy_q;
    logic [1:0]         beat_q;
    logic [31:0]        adr_q;
    bus_pkg::line_cmd_t cmd_q;
    cache_pkg::line_u   buf_q;
    logic               single;
    logic               last;

    assign single = (cmd_q.op == bus_pkg::SINGLE);
    // Single transfers end on their only ack
    assign last   = single || (beat_q == 2'(cache_pkg::LINE_WORDS - 1));
    assign done_o = busy_q && wb_i.ack && last;

    // ========================================
    // Beat sequencing
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
            beat_q <= 2'd0;
        end else if (!busy_q) begin
            busy_q <= start_i;
            beat_q <= 2'd0;
        end else if (wb_i.ack) begin
            busy_q <= !last;
            beat_q <= beat_q + 2'd1;
        end
    end

    // Job and address step, one word per ack
    always_ff @(posedge clk) begin
        if (!busy_q && start_i) begin
            cmd_q <= cmd_i;
            adr_q <= cmd_i.base;
        end else if (busy_q && wb_i.ack) begin
            adr_q <= adr_q + 32'd4;
        end
    end

    // Read beats collected by word
    always_ff @(posedge clk) begin
        if (busy_q && wb_i.ack && cmd_q.op == bus_pkg::LINE_READ)
            buf_q.words[beat_q] <= wb_i.dat;
    end

    // ========================================
    // Bus drive
    // ========================================
    // Everything below is registered, so it holds until ack
    always_comb begin
        wb_o     = '0;
        wb_o.cyc = busy_q;
        wb_o.stb = busy_q;
        wb_o.adr = adr_q;
        wb_o.we  = (cmd_q.op == bus_pkg::LINE_WRITE) || (single && cmd_q.swe);
        wb_o.sel = single ? cmd_q.sel : 4'hf;
        wb_o.dat = single ? cmd_q.sdata : cmd_q.line.words[beat_q];
    end

    // Last word is taken live off the bus
    always_comb begin
        line_o               = buf_q;
        line_o.words[beat_q] = wb_i.dat;
    end

    assign word_o = wb_i.dat;

endmodule

`default_nettype wire

/* design/dcache_ctrl.sv */
`default_nettype none

module dcache_ctrl #(
    parameter logic [31:0] CACHEABLE_BASE = 32'h8000_0000,
    parameter logic [31:0] CACHEABLE_MASK = 32'hff80_0000
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire bus_pkg::cpu_req_t  cpu_req_i,
    output bus_pkg::cpu_rsp_t       cpu_rsp_o,
    input  wire logic               hit_i,
    input  wire logic [31:0]        hit_word_i,
    input  wire cache_pkg::victim_t victim_i,
    output logic                    wr_hit_o,
    output cache_pkg::fill_t        fill_o,
    output logic                    fill_valid_o,
    output bus_pkg::line_cmd_t      cmd_o,
    output logic                    start_o,
    input  wire logic               done_i,
    input  wire cache_pkg::line_u   line_i,
    input  wire logic [31:0]        word_i
);

    // Start states pulse start for one cycle, wait states sit until done
    typedef enum logic [2:0] {
        S_IDLE,
        S_WB_START,
        S_WB_WAIT,
        S_RD_START,
        S_RD_WAIT,
        S_BY_START,
        S_BY_WAIT
    } state_e;

    state_e             state_q;
    state_e             state_d;
    bus_pkg::cpu_req_t  req_q;
    cache_pkg::victim_t victim_q;
    cache_pkg::line_u   merged;
    logic               cacheable;
    logic               idle_hit;

    // ========================================
    // Classification
    // ========================================
    assign cacheable = ((cpu_req_i.addr & CACHEABLE_MASK) == CACHEABLE_BASE);
    assign idle_hit  = (state_q == S_IDLE) && cpu_req_i.valid && cacheable && hit_i;

    // Write hits go straight into the store
    assign wr_hit_o = idle_hit && cpu_req_i.we;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (cpu_req_i.valid && !idle_hit) begin
                    if (!cacheable)
                        state_d = S_BY_START;
                    else if (victim_i.dirty)
                        state_d = S_WB_START;
                    else
                        state_d = S_RD_START;
                end
            end
            S_WB_START: state_d = S_WB_WAIT;
            // Eviction finished, refill follows
            S_WB_WAIT:  if (done_i) state_d = S_RD_START;
            S_RD_START: state_d = S_RD_WAIT;
            S_RD_WAIT:  if (done_i) state_d = S_IDLE;
            S_BY_START: state_d = S_BY_WAIT;
            S_BY_WAIT:  if (done_i) state_d = S_IDLE;
            default:    state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request and victim held for the whole miss
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && cpu_req_i.valid && !idle_hit) begin
            req_q    <= cpu_req_i;
            victim_q <= victim_i;
        end
    end

    // ========================================
    // Memory jobs
    // ========================================
    assign start_o = (state_q == S_WB_START) || (state_q == S_RD_START) ||
                     (state_q == S_BY_START);

    always_comb begin
        cmd_o       = '0;
        cmd_o.sdata = req_q.wdata;
        cmd_o.swe   = req_q.we;
        cmd_o.sel   = req_q.be;
        case (state_q)
            S_WB_START: begin
                cmd_o.op   = bus_pkg::LINE_WRITE;
                cmd_o.base = {victim_q.tag, req_q.addr.index, 4'b0000};
                cmd_o.line = victim_q.line;
            end
            S_BY_START: begin
                cmd_o.op   = bus_pkg::SINGLE;
                cmd_o.base = req_q.addr;
            end
            default: begin
                cmd_o.op   = bus_pkg::LINE_READ;
                cmd_o.base = {req_q.addr.tag, req_q.addr.index, 4'b0000};
            end
        endcase
    end

    // ========================================
    // Refill completion
    // ========================================
    // Write-allocate: store lands on top of the fetched word
    always_comb begin
        merged = line_i;
        if (req_q.we)
            merged.words[req_q.addr.word] = cache_pkg::merge_bytes(
                line_i.words[req_q.addr.word], req_q.wdata, req_q.be);
    end

    assign fill_o.index  = req_q.addr.index;
    assign fill_o.tag    = req_q.addr.tag;
    assign fill_o.line   = merged;
    assign fill_o.dirty  = req_q.we;
    assign fill_valid_o  = (state_q == S_RD_WAIT) && done_i;

    // ========================================
    // CPU response
    // ========================================
    always_comb begin
        cpu_rsp_o = '0;
        if (idle_hit) begin
            cpu_rsp_o.ready = 1'b1;
            cpu_rsp_o.rdata = cpu_req_i.we ? 32'h0 : hit_word_i;
        end else if (state_q == S_RD_WAIT && done_i) begin
            // Requested word comes from the live line
            cpu_rsp_o.ready = 1'b1;
            cpu_rsp_o.rdata = req_q.we ? 32'h0 : line_i.words[req_q.addr.word];
        end else if (state_q == S_BY_WAIT && done_i) begin
            cpu_rsp_o.ready = 1'b1;
            cpu_rsp_o.rdata = req_q.we ? 32'h0 : word_i;
        end
    end

endmodule

`default_nettype wire

/* design/dcache_top.sv */
`default_nettype none

module dcache_top #(
    parameter logic [31:0] CACHEABLE_BASE = 32'h8000_0000,
    parameter logic [31:0] CACHEABLE_MASK = 32'hff80_0000
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire bus_pkg::cpu_req_t cpu_req_i,
    output bus_pkg::cpu_rsp_t      cpu_rsp_o,
    output bus_pkg::wb_req_t       wb_o,
    input  wire bus_pkg::wb_rsp_t  wb_i
);

    // ========================================
    // Store <-> controller
    // ========================================
    logic               hit;
    logic [31:0]        hit_word;
    cache_pkg::victim_t victim;
    logic               wr_hit;
    cache_pkg::fill_t   fill;
    logic               fill_valid;

    // Controller <-> line master
    bus_pkg::line_cmd_t cmd;
    logic               start;
    logic               done;
    cache_pkg::line_u   line;
    logic [31:0]        word;

    dcache_ctrl #(
        .CACHEABLE_BASE (CACHEABLE_BASE),
        .CACHEABLE_MASK (CACHEABLE_MASK)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_req_i    (cpu_req_i),
        .cpu_rsp_o    (cpu_rsp_o),
        .hit_i        (hit),
        .hit_word_i   (hit_word),
        .victim_i     (victim),
        .wr_hit_o     (wr_hit),
        .fill_o       (fill),
        .fill_valid_o (fill_valid),
        .cmd_o        (cmd),
        .start_o      (start),
        .done_i       (done),
        .line_i       (line),
        .word_i       (word)
    );

    // Lookup runs on the live CPU address
    l1_store u_store (
        .clk           (clk),
        .rst           (rst),
        .lookup_addr_i (cpu_req_i.addr),
        .hit_o         (hit),
        .hit_word_o    (hit_word),
        .victim_o      (victim),
        .wr_hit_i      (wr_hit),
        .wdata_i       (cpu_req_i.wdata),
        .be_i          (cpu_req_i.be),
        .fill_i        (fill),
        .fill_valid_i  (fill_valid)
    );

    wb_line_master u_master (
        .clk     (clk),
        .rst     (rst),
        .start_i (start),
        .cmd_i   (cmd),
        .done_o  (done),
        .line_o  (line),
        .word_o  (word),
        .wb_o    (wb_o),
        .wb_i    (wb_i)
    );

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset released just after an edge, like every other input
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* sim/wb_mem_model.sv */
`default_nettype none

module wb_mem_model (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire bus_pkg::wb_req_t wb_i,
    output bus_pkg::wb_rsp_t      wb_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] PATTERN = 32'h5a5a_5a5a;

    // Low 8 KB of each region, region picked by address bit 28
    logic [31:0]      mem     [4096];
    logic             written [4096];
    int unsigned      delay_q;
    int unsigned      xfer_count;
    bus_pkg::wb_req_t wr_log  [$];

    function automatic int unsigned slot_of(input logic [31:0] adr);
        return {adr[28], adr[12:2]};
    endfunction

    // Untouched words read back as their own address XOR the pattern
    function automatic logic [31:0] read_word(input logic [31:0] adr);
        if (written[slot_of(adr)])
            return mem[slot_of(adr)];
        return {adr[31:2], 2'b00} ^ PATTERN;
    endfunction

    initial begin
        xfer_count = 0;
        for (int i = 0; i < 4096; i++)
            written[i] = 1'b0;
    end

    // ========================================
    // Slave side, registered ack
    // ========================================
    always @(posedge clk or posedge rst) begin
        logic [31:0] word;
        if (rst) begin
            wb_o    <= '0;
            delay_q <= 0;
        end else if (wb_o.ack) begin
            // One ack per beat, then a fresh random wait
            wb_o.ack <= 1'b0;
            delay_q  <= $urandom_range(0, 3);
        end else if (wb_i.cyc && wb_i.stb) begin
            if (delay_q != 0) begin
                delay_q <= delay_q - 1;
            end else begin
                wb_o.ack   <= 1'b1;
                xfer_count <= xfer_count + 1;
                if (wb_i.we) begin
                    word = read_word(wb_i.adr);
                    for (int b = 0; b < 4; b++)
                        if (wb_i.sel[b]) word[8*b +: 8] = wb_i.dat[8*b +: 8];
                    mem[slot_of(wb_i.adr)]     = word;
                    written[slot_of(wb_i.adr)] = 1'b1;
                    wr_log.push_back(wb_i);
                end else begin
                    wb_o.dat <= read_word(wb_i.adr);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sim/dcache_sva.sv */
`default_nettype none

module dcache_sva (
    input wire logic              clk,
    input wire logic              rst,
    input wire bus_pkg::cpu_req_t cpu_req_i,
    input wire bus_pkg::cpu_rsp_t cpu_rsp_o,
    input wire bus_pkg::wb_req_t  wb_o,
    input wire bus_pkg::wb_rsp_t  wb_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // Bus cycle closes once the access it served has completed
    cyc_closes: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp_o.ready && wb_i.ack |=> !wb_o.cyc)
        else begin $error("bus cycle still open after the access completed"); fail_count++; end

    // Master holds the beat until the slave acks it
    req_stable: assert property (@(posedge clk) disable iff (rst)
        wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr) && $stable(wb_o.dat) &&
                                  $stable(wb_o.we) && $stable(wb_o.sel))
        else begin $error("wishbone request changed before ack"); fail_count++; end

    ready_needs_valid: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp_o.ready |-> cpu_req_i.valid)
        else begin $error("ready raised without valid"); fail_count++; end

    // A completion without an ack is a hit, and hits stay off the bus
    hit_no_bus: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp_o.ready && !wb_i.ack |-> !wb_o.cyc)
        else begin $error("bus cycle open during a hit"); fail_count++; end

endmodule

bind dcache_top dcache_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .cpu_req_i (cpu_req_i),
    .cpu_rsp_o (cpu_rsp_o),
    .wb_o      (wb_o),
    .wb_i      (wb_i)
);

`default_nettype wire

/* sim/tb_dcache.sv */
`default_nettype none

module tb_dcache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] PATTERN = 32'h5a5a_5a5a;
    // Worst access is a dirty miss with two start cycles and eight beats
    // Registered ack plus up to three wait cycles gives five cycles a beat
    localparam int BEAT_MAX      = 5;
    localparam int WORST_ACCESS  = 2 * (1 + cache_pkg::LINE_WORDS * BEAT_MAX) + 2;
    localparam int ACCESSES      = 16 + 200;
    localparam int TIMEOUT_LIMIT = ACCESSES * WORST_ACCESS + 8 + 100;

    logic              clk;
    logic              rst;
    bus_pkg::cpu_req_t cpu_req;
    bus_pkg::cpu_rsp_t cpu_rsp;
    bus_pkg::wb_req_t  wb_req;
    bus_pkg::wb_rsp_t  wb_rsp;

    // Shadow of what the CPU should see, same slots as the memory model
    logic [31:0] shadow_mem   [4096];
    logic        shadow_valid [4096];
    int          test_errors;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          cycles;

    tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(8)) u_clk (.clk_o(clk), .rst_o(rst));

    wb_mem_model u_mem (.clk(clk), .rst(rst), .wb_i(wb_req), .wb_o(wb_rsp));

    dcache_top dut (
        .clk       (clk),
        .rst       (rst),
        .cpu_req_i (cpu_req),
        .cpu_rsp_o (cpu_rsp),
        .wb_o      (wb_req),
        .wb_i      (wb_rsp)
    );

    // ========================================
    // Shadow model
    // ========================================
    function automatic int unsigned shadow_slot(input logic [31:0] a);
        return {a[28], a[12:2]};
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        if (shadow_valid[shadow_slot(a)])
            return shadow_mem[shadow_slot(a)];
        return {a[31:2], 2'b00} ^ PATTERN;
    endfunction

    task automatic shadow_store(input logic [31:0] a, input logic [31:0] d, input logic [3:0] be);
        logic [31:0] w;
        w = expected_word(a);
        for (int b = 0; b < 4; b++)
            if (be[b]) w[8*b +: 8] = d[8*b +: 8];
        shadow_mem[shadow_slot(a)]   = w;
        shadow_valid[shadow_slot(a)] = 1'b1;
    endtask

    // ========================================
    // Checks
    // ========================================
    task automatic check_word(input string name, input bus_pkg::cpu_rsp_t rsp,
                              input logic [31:0] exp);
        if (rsp.rdata !== exp) begin
            $display("mismatch %s: expected %h actual %h", name, exp, rsp.rdata);
            test_errors++;
        end
    endtask

    task automatic check_wb_write(input string name, input bus_pkg::wb_req_t got,
                                  input logic [31:0] adr, input logic [31:0] dat,
                                  input logic [3:0] sel);
        if (got.adr !== adr || got.dat !== dat || got.sel !== sel || got.we !== 1'b1) begin
            $display("mismatch %s: expected adr %h dat %h sel %b actual adr %h dat %h sel %b",
                     name, adr, dat, sel, got.adr, got.dat, got.sel);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %-18s ok", name);
        end else begin
            $display("test %-18s %0d errors", name, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    // ========================================
    // CPU access
    // ========================================
    // Drive after the edge, sample the combinational response mid cycle
    task automatic cpu_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] be, output bus_pkg::cpu_rsp_t rsp,
                              output logic bus_used);
        bus_used      = 1'b0;
        cpu_req.valid = 1'b1;
        cpu_req.we    = we;
        cpu_req.be    = be;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        forever begin
            @(negedge clk);
            if (wb_req.cyc)
                bus_used = 1'b1;
            if (cpu_rsp.ready)
                break;
        end
        rsp = cpu_rsp;
        @(posedge clk);
        #2;
        cpu_req = '0;
    endtask

    task automatic load(input string name, input logic [31:0] addr, output logic bus_used);
        bus_pkg::cpu_rsp_t rsp;
        cpu_access(1'b0, addr, 32'h0, 4'hf, rsp, bus_used);
        check_word(name, rsp, expected_word(addr));
    endtask

    // Stores answer with zero data
    task automatic store(input string name, input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] be, output logic bus_used);
        bus_pkg::cpu_rsp_t rsp;
        cpu_access(1'b1, addr, data, be, rsp, bus_used);
        check_word(name, rsp, 32'h0);
        shadow_store(addr, data, be);
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic read_miss_then_hit();
        logic used;
        load("read_miss_then_hit", 32'h8000_0040, used);
        load("read_miss_then_hit", 32'h8000_0040, used);
        if (used) begin
            $display("error read_miss_then_hit: second read of the line went to the bus");
            test_errors++;
        end
        finish_test("read_miss_then_hit");
    endtask

    task automatic write_hit_bytes();
        logic used;
        load("write_hit_bytes", 32'h8000_0080, used);
        store("write_hit_bytes", 32'h8000_0084, 32'hdead_beef, 4'b0101, used);
        if (used) begin
            $display("error write_hit_bytes: store hit went to the bus");
            test_errors++;
        end
        load("write_hit_bytes", 32'h8000_0084, used);
        finish_test("write_hit_bytes");
    endtask

    task automatic write_allocate();
        logic used;
        store("write_allocate", 32'h8000_00c8, 32'h1234_5678, 4'hf, used);
        load("write_allocate", 32'h8000_00c8, used);
        load("write_allocate", 32'h8000_00c4, used);
        finish_test("write_allocate");
    endtask

    // Same index, tag one higher, so B pushes the dirty A line out
    task automatic dirty_eviction();
        logic [31:0] a_base;
        logic [31:0] b_base;
        int          n0;
        logic        used;
        a_base = 32'h8000_0100;
        b_base = 32'h8000_0500;
        store("dirty_eviction", a_base + 32'h4, 32'hcafe_f00d, 4'hf, used);
        n0 = u_mem.wr_log.size();
        load("dirty_eviction", b_base + 32'h8, used);
        if (u_mem.wr_log.size() != n0 + 4) begin
            $display("error dirty_eviction: expected 4 line writes, memory saw %0d",
                     u_mem.wr_log.size() - n0);
            test_errors++;
        end else begin
            for (int i = 0; i < 4; i++)
                check_wb_write("dirty_eviction", u_mem.wr_log[n0 + i], a_base + 4 * i,
                               expected_word(a_base + 4 * i), 4'hf);
        end
        load("dirty_eviction", a_base + 32'h4, used);
        finish_test("dirty_eviction");
    endtask

    task automatic bypass();
        int   n_log;
        int   n_xfer;
        logic used;
        n_log  = u_mem.wr_log.size();
        n_xfer = u_mem.xfer_count;
        store("bypass", 32'h1000_0010, 32'h0bad_cafe, 4'b0011, used);
        if (u_mem.xfer_count != n_xfer + 1 || u_mem.wr_log.size() != n_log + 1) begin
            $display("error bypass: store did not make exactly one bus transfer");
            test_errors++;
        end else begin
            check_wb_write("bypass", u_mem.wr_log[n_log], 32'h1000_0010, 32'h0bad_cafe, 4'b0011);
        end
        n_xfer = u_mem.xfer_count;
        load("bypass", 32'h1000_0010, used);
        if (u_mem.xfer_count != n_xfer + 1) begin
            $display("error bypass: load did not make exactly one bus transfer");
            test_errors++;
        end
        finish_test("bypass");
    endtask

    // Four tags over two sets keep evicting, plus a bit of the bypass region
    task automatic random_mix();
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  be;
        int          pick;
        logic        used;
        for (int i = 0; i < 200; i++) begin
            pick = $urandom_range(0, 7);
            if (pick == 0)
                addr = 32'h1000_0000 | ($urandom_range(0, 15) << 2);
            else
                addr = 32'h8000_0000 | ($urandom_range(0, 3) << 10) |
                       ((5 + $urandom_range(0, 1)) << 4) | ($urandom_range(0, 3) << 2);
            data = $urandom;
            be   = 4'($urandom_range(1, 15));
            if ($urandom_range(0, 1) == 1)
                store("random_mix", addr, data, be, used);
            else
                load("random_mix", addr, used);
        end
        finish_test("random_mix");
    endtask

    // ========================================
    // Run control
    // ========================================
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_LIMIT) begin
            $display("error: run passed %0d cycles without finishing", TIMEOUT_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h1f70_a402));
        cpu_req      = '0;
        test_errors  = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycles       = 0;
        for (int i = 0; i < 4096; i++)
            shadow_valid[i] = 1'b0;
        wait (rst == 1'b0);
        @(posedge clk);
        #2;
        read_miss_then_hit();
        write_hit_bytes();
        write_allocate();
        dirty_eviction();
        bypass();
        random_mix();
        errors += dut.u_sva.fail_count;
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, dut.u_sva.fail_count);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
design/cache_pkg.sv
design/bus_pkg.sv
design/l1_store.sv
design/wb_line_master.sv
design/dcache_ctrl.sv
design/dcache_top.sv
sim/tb_clk_gen.sv
sim/wb_mem_model.sv
sim/dcache_sva.sv
sim/tb_dcache.sv
